// ==== hw/rv_ex_settings.svh ====
`ifndef RV_EX_SETTINGS_SVH
`define RV_EX_SETTINGS_SVH

// width of one integer register / data word
`define RV_XLEN 64

// register index width, x0 to x31
`define RV_REG_AW 5

// pc seen downstream right after reset
`define RV_RESET_PC 64'h0000_0000_8000_0000

`endif

// ==== hw/rv_ex_pkg.sv ====
`default_nettype none

`include "rv_ex_settings.svh"

package rv_ex_pkg;

	typedef logic [`RV_XLEN-1:0]   xlen_t;
	typedef logic [`RV_REG_AW-1:0] reg_addr_t;
	typedef logic [`RV_XLEN-1:0]   pc_t;

	// execute op codes, single-cycle ones first
	typedef enum logic [4:0] {
		OP_ADD   = 5'd0,
		OP_SUB   = 5'd1,
		OP_AND   = 5'd2,
		OP_OR    = 5'd3,
		OP_XOR   = 5'd4,
		OP_SLL   = 5'd5,
		OP_SRL   = 5'd6,
		OP_SRA   = 5'd7,
		OP_SLT   = 5'd8,
		OP_SLTU  = 5'd9,
		OP_MUL   = 5'd16, // multi-cycle group
		OP_MULHU = 5'd17,
		OP_DIV   = 5'd18,
		OP_DIVU  = 5'd19,
		OP_REM   = 5'd20,
		OP_REMU  = 5'd21
	} alu_op_e;

	typedef enum logic [1:0] {
		MD_IDLE = 2'd0,
		MD_RUN  = 2'd1,
		MD_DONE = 2'd2
	} md_state_e;

endpackage

`default_nettype wire

// ==== hw/rv_alu.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv_alu (
	input  wire rv_ex_pkg::alu_op_e alu_op_i,
	input  wire rv_ex_pkg::xlen_t   a_i,
	input  wire rv_ex_pkg::xlen_t   b_i,
	output rv_ex_pkg::xlen_t        res_o
);

	localparam int XLEN = $bits(rv_ex_pkg::xlen_t);
	localparam int SHW  = $clog2(XLEN);

	logic [SHW-1:0] shamt;
	logic           lt_signed;
	logic           lt_unsigned;

	assign shamt       = b_i[SHW-1:0]; // only low bits count for shifts
	assign lt_signed   = $signed(a_i) < $signed(b_i);
	assign lt_unsigned = a_i < b_i;

	always_comb begin
		case (alu_op_i)
			rv_ex_pkg::OP_ADD: begin
				res_o = a_i + b_i;
			end
			rv_ex_pkg::OP_SUB: begin
				res_o = a_i - b_i;
			end
			rv_ex_pkg::OP_AND: begin
				res_o = a_i & b_i;
			end
			rv_ex_pkg::OP_OR: begin
				res_o = a_i | b_i;
			end
			rv_ex_pkg::OP_XOR: begin
				res_o = a_i ^ b_i;
			end
			rv_ex_pkg::OP_SLL: begin
				res_o = a_i << shamt;
			end
			rv_ex_pkg::OP_SRL: begin
				res_o = a_i >> shamt;
			end
			rv_ex_pkg::OP_SRA: begin
				res_o = rv_ex_pkg::xlen_t'($signed(a_i) >>> shamt); // sign fill
			end
			rv_ex_pkg::OP_SLT: begin
				res_o = rv_ex_pkg::xlen_t'(lt_signed);
			end
			rv_ex_pkg::OP_SLTU: begin
				res_o = rv_ex_pkg::xlen_t'(lt_unsigned);
			end
			// mul/div codes land here, result comes from muldiv
			default: begin
				res_o = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== hw/rv_muldiv.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv_muldiv (
	input  wire                     clk,
	input  wire                     rst_n,
	input  wire                     issue_valid_i,
	input  wire rv_ex_pkg::alu_op_e alu_op_i,
	input  wire rv_ex_pkg::xlen_t   a_i,
	input  wire rv_ex_pkg::xlen_t   b_i,
	input  wire                     flush_i,
	output logic                    busy_o,
	output logic                    done_o,
	output rv_ex_pkg::xlen_t        res_o
);

	localparam int XLEN  = $bits(rv_ex_pkg::xlen_t);
	localparam int CNT_W = $clog2(XLEN);

	rv_ex_pkg::md_state_e state_q;
	rv_ex_pkg::alu_op_e   op_q;
	logic [CNT_W-1:0]     cnt_q;
	logic                 q_neg_q; // quotient needs negation at the end
	logic                 r_neg_q; // remainder follows dividend sign
	logic [2*XLEN-1:0]    acc_q;   // product, or {remainder, quotient}
	rv_ex_pkg::xlen_t     opb_q;   // multiplicand or divisor

	logic             start;
	logic             signed_div;
	logic             a_neg;
	logic             b_neg;
	rv_ex_pkg::xlen_t a_abs;
	rv_ex_pkg::xlen_t b_abs;
	logic [XLEN:0]    mul_sum;
	logic [XLEN:0]    div_shift;
	logic [XLEN:0]    div_diff;

	function automatic logic op_is_div(input rv_ex_pkg::alu_op_e op);
		return (op == rv_ex_pkg::OP_DIV) || (op == rv_ex_pkg::OP_DIVU) ||
			(op == rv_ex_pkg::OP_REM) || (op == rv_ex_pkg::OP_REMU);
	endfunction

	function automatic logic op_is_md(input rv_ex_pkg::alu_op_e op);
		return (op == rv_ex_pkg::OP_MUL) || (op == rv_ex_pkg::OP_MULHU) || op_is_div(op);
	endfunction

	assign start  = issue_valid_i && op_is_md(alu_op_i) && !flush_i &&
		(state_q == rv_ex_pkg::MD_IDLE);
	assign busy_o = start || (state_q == rv_ex_pkg::MD_RUN); // stall from presentation on
	assign done_o = (state_q == rv_ex_pkg::MD_DONE);

	assign signed_div = (alu_op_i == rv_ex_pkg::OP_DIV) || (alu_op_i == rv_ex_pkg::OP_REM);
	assign a_neg      = signed_div && a_i[XLEN-1];
	assign b_neg      = signed_div && b_i[XLEN-1];
	assign a_abs      = a_neg ? -a_i : a_i;
	assign b_abs      = b_neg ? -b_i : b_i;

	// one shift-add step
	assign mul_sum   = {1'b0, acc_q[2*XLEN-1:XLEN]} + (acc_q[0] ? {1'b0, opb_q} : '0);
	// one restoring step, remainder shifted left by the next dividend bit
	assign div_shift = acc_q[2*XLEN-1:XLEN-1];
	assign div_diff  = div_shift - {1'b0, opb_q};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= rv_ex_pkg::MD_IDLE;
			op_q    <= rv_ex_pkg::OP_ADD;
			cnt_q   <= '0;
			q_neg_q <= 1'b0;
			r_neg_q <= 1'b0;
		end else if (flush_i) begin
			state_q <= rv_ex_pkg::MD_IDLE; // abort whatever runs
		end else begin
			case (state_q)
				rv_ex_pkg::MD_IDLE: begin
					if (start) begin
						state_q <= rv_ex_pkg::MD_RUN;
						op_q    <= alu_op_i;
						cnt_q   <= '0;
						// div by zero keeps the all-ones quotient
						q_neg_q <= (a_neg ^ b_neg) && (b_i != '0);
						r_neg_q <= a_neg;
					end
				end
				rv_ex_pkg::MD_RUN: begin
					cnt_q <= cnt_q + 1'b1;
					if (cnt_q == CNT_W'(XLEN - 1))
						state_q <= rv_ex_pkg::MD_DONE;
				end
				default: begin
					state_q <= rv_ex_pkg::MD_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			if (op_is_div(alu_op_i)) begin
				acc_q <= {{XLEN{1'b0}}, a_abs};
				opb_q <= b_abs;
			end else begin
				acc_q <= {{XLEN{1'b0}}, b_i}; // multiplier in low half
				opb_q <= a_i;
			end
		end else if (state_q == rv_ex_pkg::MD_RUN) begin
			if (!op_is_div(op_q))
				acc_q <= {mul_sum, acc_q[XLEN-1:1]};
			else if (div_diff[XLEN])
				acc_q <= {div_shift[XLEN-1:0], acc_q[XLEN-2:0], 1'b0}; // restore
			else
				acc_q <= {div_diff[XLEN-1:0], acc_q[XLEN-2:0], 1'b1};
		end
	end

	always_comb begin
		case (op_q)
			rv_ex_pkg::OP_MUL:   res_o = acc_q[XLEN-1:0];
			rv_ex_pkg::OP_MULHU: res_o = acc_q[2*XLEN-1:XLEN];
			rv_ex_pkg::OP_DIV,
			rv_ex_pkg::OP_DIVU:  res_o = q_neg_q ? -acc_q[XLEN-1:0] : acc_q[XLEN-1:0];
			rv_ex_pkg::OP_REM,
			rv_ex_pkg::OP_REMU:  res_o = r_neg_q ? -acc_q[2*XLEN-1:XLEN] : acc_q[2*XLEN-1:XLEN];
			default:             res_o = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== hw/rv_ex_mem_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv_ex_mem_regs #(
	parameter rv_ex_pkg::pc_t RESET_PC = '0
) (
	input  wire                       clk,
	input  wire                       rst_n,
	input  wire                       issue_valid_i,
	input  wire                       flush_i,
	input  wire                       md_busy_i,
	input  wire                       md_done_i,
	input  wire rv_ex_pkg::xlen_t     alu_res_i,
	input  wire rv_ex_pkg::xlen_t     md_res_i,
	input  wire rv_ex_pkg::reg_addr_t rd_i,
	input  wire                       reg_wen_i,
	input  wire rv_ex_pkg::pc_t       pc_i,
	output logic                      valid_o,
	output logic                      reg_wen_o,
	output rv_ex_pkg::xlen_t          result_o,
	output rv_ex_pkg::reg_addr_t      rd_o,
	output rv_ex_pkg::pc_t            pc_o
);

	rv_ex_pkg::xlen_t res_sel;

	// finished muldiv wins over the alu result
	assign res_sel = md_done_i ? md_res_i : alu_res_i;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_o   <= 1'b0;
			reg_wen_o <= 1'b0;
			result_o  <= '0;
			rd_o      <= '0;
			pc_o      <= RESET_PC;
		end else if (flush_i) begin
			// bubble, data fields keep their value
			valid_o   <= 1'b0;
			reg_wen_o <= 1'b0;
		end else if (md_busy_i) begin
			valid_o   <= 1'b0; // stalled, hold the rest
		end else begin
			valid_o   <= issue_valid_i;
			reg_wen_o <= issue_valid_i && reg_wen_i; // no write from an empty slot
			result_o  <= res_sel;
			rd_o      <= rd_i;
			pc_o      <= pc_i;
		end
	end

endmodule

`default_nettype wire

// ==== hw/rv_ex_top.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "rv_ex_settings.svh"

module rv_ex_top (
	input  wire                       clk,
	input  wire                       rst_n,
	// issue side
	input  wire                       issue_valid_i,
	input  wire rv_ex_pkg::alu_op_e   alu_op_i,
	input  wire rv_ex_pkg::xlen_t     src1_i,
	input  wire rv_ex_pkg::xlen_t     src2_i,
	input  wire rv_ex_pkg::reg_addr_t rd_i,
	input  wire                       reg_wen_i,
	input  wire rv_ex_pkg::pc_t       pc_i,
	input  wire                       flush_i,
	output logic                      stall_o,
	// towards mem stage
	output logic                      valid_o,
	output rv_ex_pkg::xlen_t          result_o,
	output rv_ex_pkg::reg_addr_t      rd_o,
	output logic                      reg_wen_o,
	output rv_ex_pkg::pc_t            pc_o
);

	rv_ex_pkg::xlen_t alu_res;
	rv_ex_pkg::xlen_t md_res;
	logic             md_done;

	rv_alu u_alu (
		.alu_op_i (alu_op_i),
		.a_i      (src1_i),
		.b_i      (src2_i),
		.res_o    (alu_res)
	);

	rv_muldiv u_muldiv (
		.clk           (clk),
		.rst_n         (rst_n),
		.issue_valid_i (issue_valid_i),
		.alu_op_i      (alu_op_i),
		.a_i           (src1_i),
		.b_i           (src2_i),
		.flush_i       (flush_i),
		.busy_o        (stall_o),  // busy is the stage stall
		.done_o        (md_done),
		.res_o         (md_res)
	);

	rv_ex_mem_regs #(
		.RESET_PC (`RV_RESET_PC)
	) u_ex_mem (
		.clk           (clk),
		.rst_n         (rst_n),
		.issue_valid_i (issue_valid_i),
		.flush_i       (flush_i),
		.md_busy_i     (stall_o),
		.md_done_i     (md_done),
		.alu_res_i     (alu_res),
		.md_res_i      (md_res),
		.rd_i          (rd_i),
		.reg_wen_i     (reg_wen_i),
		.pc_i          (pc_i),
		.valid_o       (valid_o),
		.reg_wen_o     (reg_wen_o),
		.result_o      (result_o),
		.rd_o          (rd_o),
		.pc_o          (pc_o)
	);

endmodule

`default_nettype wire

// ==== dv/tb_clkgen.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_clkgen (
	output logic clk_o,
	output logic rst_n_o
);

	initial begin
		clk_o = 1'b0;
		forever #50 clk_o = ~clk_o; // 100 ns period
	end

	initial begin
		rst_n_o = 1'b0;
		repeat (3) @(posedge clk_o);
		@(negedge clk_o);
		rst_n_o = 1'b1; // release away from the active edge
	end

endmodule

`default_nettype wire

// ==== dv/rv_ex_props.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv_ex_props (
	input wire                       clk,
	input wire                       rst_n,
	input wire                       flush_i,
	input wire                       stall_i,
	input wire                       valid_i,
	input wire                       md_done_i,
	input wire rv_ex_pkg::md_state_e md_state_i
);

	localparam int XLEN = $bits(rv_ex_pkg::xlen_t);

	logic [7:0] stall_cnt; // length of the current stall

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			stall_cnt <= '0;
		else if (stall_i)
			stall_cnt <= stall_cnt + 8'd1;
		else
			stall_cnt <= '0;
	end

	// a stalled cycle never hands anything downstream
	no_valid_after_stall: assert property (@(posedge clk) disable iff (!rst_n)
		stall_i |=> !valid_i)
		else $error("valid_o after a stalled cycle");

	// muldiv result goes out right after its done cycle
	done_gives_valid: assert property (@(posedge clk) disable iff (!rst_n)
		(md_done_i && !flush_i) |=> valid_i)
		else $error("no valid_o after muldiv done");

	stall_bounded: assert property (@(posedge clk) disable iff (!rst_n)
		stall_cnt <= 8'd70)
		else $error("stall_o high for more than 70 cycles");

	// done only after a full run started from idle
	state_legal: assert property (@(posedge clk) disable iff (!rst_n)
		(md_state_i == rv_ex_pkg::MD_DONE) |->
		($past(md_state_i, XLEN) == rv_ex_pkg::MD_RUN) &&
		($past(md_state_i, XLEN + 1) == rv_ex_pkg::MD_IDLE))
		else $error("muldiv done without a full run");

endmodule

bind rv_ex_top rv_ex_props u_props (
	.clk        (clk),
	.rst_n      (rst_n),
	.flush_i    (flush_i),
	.stall_i    (stall_o),
	.valid_i    (valid_o),
	.md_done_i  (md_done),
	.md_state_i (u_muldiv.state_q)
);

`default_nettype wire

// ==== dv/rv_ex_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "rv_ex_settings.svh"

module rv_ex_tb;

	typedef struct packed {
		rv_ex_pkg::xlen_t     res;
		rv_ex_pkg::reg_addr_t rd;
		logic                 wen;
		rv_ex_pkg::pc_t       pc;
	} exp_entry_t;

	localparam int STALL_LIMIT = 80;

	logic                 clk;
	logic                 rst_n;
	logic                 issue_valid;
	rv_ex_pkg::alu_op_e   alu_op;
	rv_ex_pkg::xlen_t     src1;
	rv_ex_pkg::xlen_t     src2;
	rv_ex_pkg::reg_addr_t rd;
	logic                 reg_wen;
	rv_ex_pkg::pc_t       pc;
	logic                 flush;
	logic                 stall;
	logic                 valid;
	rv_ex_pkg::xlen_t     result;
	rv_ex_pkg::reg_addr_t rd_out;
	logic                 reg_wen_out;
	rv_ex_pkg::pc_t       pc_out;

	exp_entry_t     exp_q[$];
	logic [15:0]    lfsr_q;
	rv_ex_pkg::pc_t pc_next;
	int             err_cnt;
	int             to_cnt;

	tb_clkgen u_clkgen (.clk_o(clk), .rst_n_o(rst_n));

	rv_ex_top u_dut (
		.clk (clk), .rst_n (rst_n),
		.issue_valid_i (issue_valid), .alu_op_i (alu_op),
		.src1_i (src1), .src2_i (src2), .rd_i (rd), .reg_wen_i (reg_wen),
		.pc_i (pc), .flush_i (flush), .stall_o (stall),
		.valid_o (valid), .result_o (result), .rd_o (rd_out),
		.reg_wen_o (reg_wen_out), .pc_o (pc_out)
	);

	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	// one lfsr step per bit taken
	task automatic take_bits(input int n, output rv_ex_pkg::xlen_t v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = lfsr_step(lfsr_q);
			v = {v[62:0], lfsr_q[0]};
		end
	endtask

	function automatic rv_ex_pkg::xlen_t rv_ex_ref(input rv_ex_pkg::alu_op_e op,
		input rv_ex_pkg::xlen_t a, input rv_ex_pkg::xlen_t b);
		logic [127:0]     prod;
		rv_ex_pkg::xlen_t min_neg;
		rv_ex_pkg::xlen_t quo_s;
		rv_ex_pkg::xlen_t rem_s;
		logic             ovf;
		min_neg = {1'b1, 63'b0};
		ovf = (a == min_neg) && (b == '1);
		prod = {64'b0, a} * {64'b0, b};
		// zero divisor and overflow per the riscv rules
		quo_s = '1;
		rem_s = a;
		if (ovf) begin
			quo_s = min_neg;
			rem_s = '0;
		end else if (b != '0) begin
			quo_s = $signed(a) / $signed(b);
			rem_s = $signed(a) % $signed(b);
		end
		case (op)
			rv_ex_pkg::OP_ADD:   return a + b;
			rv_ex_pkg::OP_SUB:   return a - b;
			rv_ex_pkg::OP_AND:   return a & b;
			rv_ex_pkg::OP_OR:    return a | b;
			rv_ex_pkg::OP_XOR:   return a ^ b;
			rv_ex_pkg::OP_SLL:   return a << b[5:0];
			rv_ex_pkg::OP_SRL:   return a >> b[5:0];
			rv_ex_pkg::OP_SRA:   return $signed(a) >>> b[5:0];
			rv_ex_pkg::OP_SLT:   return {63'b0, $signed(a) < $signed(b)};
			rv_ex_pkg::OP_SLTU:  return {63'b0, a < b};
			rv_ex_pkg::OP_MUL:   return prod[63:0];
			rv_ex_pkg::OP_MULHU: return prod[127:64];
			rv_ex_pkg::OP_DIV:   return quo_s;
			rv_ex_pkg::OP_DIVU:  return (b == '0) ? '1 : a / b;
			rv_ex_pkg::OP_REM:   return rem_s;
			rv_ex_pkg::OP_REMU:  return (b == '0) ? a : a % b;
			default:             return '0;
		endcase
	endfunction

	task automatic report_value(input string name, input rv_ex_pkg::xlen_t exp_v,
		input rv_ex_pkg::xlen_t act_v);
		$display("Fail at %0d ns: %s expected %h, got %h", $time, name, exp_v, act_v);
		err_cnt++;
	endtask

	task automatic finish_run();
		$display("errors: %0d, timeouts: %0d", err_cnt, to_cnt);
		if (err_cnt == 0 && to_cnt == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	endtask

	// drive at a falling edge, wait out any stall, expect valid_o right after acceptance
	task automatic issue_op(input rv_ex_pkg::alu_op_e op, input rv_ex_pkg::xlen_t a,
		input rv_ex_pkg::xlen_t b);
		int               waited;
		logic             md_op;
		exp_entry_t       e;
		rv_ex_pkg::xlen_t bits;
		take_bits(6, bits);
		md_op       = (op >= rv_ex_pkg::OP_MUL); // multi-cycle group
		issue_valid = 1'b1;
		alu_op      = op;
		src1        = a;
		src2        = b;
		rd          = bits[5:1];
		reg_wen     = bits[0];
		pc          = pc_next;
		pc_next     = pc_next + 64'd4;
		e.res = rv_ex_ref(op, a, b);
		e.rd  = bits[5:1];
		e.wen = bits[0];
		e.pc  = pc;
		exp_q.push_back(e);
		#1;
		if (stall !== md_op)
			report_value("stall_o", 64'(md_op), 64'(stall));
		waited = 0;
		while (stall) begin
			@(negedge clk);
			if (valid)
				report_value("valid_o during stall", 64'd0, 64'd1);
			waited++;
			if (waited > STALL_LIMIT) begin
				$display("timeout: stall_o never dropped for op %s", op.name());
				to_cnt++;
				finish_run();
			end
		end
		@(negedge clk);
		issue_valid = 1'b0;
		if (!valid)
			report_value("valid_o after accept", 64'd1, 64'd0);
	endtask

	// compare process, outputs are registered so the falling edge is stable
	always @(negedge clk) begin
		exp_entry_t e;
		if (rst_n && valid) begin
			if (exp_q.size() == 0) begin
				$display("valid_o at %0d ns with no instruction outstanding", $time);
				err_cnt++;
			end else begin
				e = exp_q.pop_front();
				if (result !== e.res)
					report_value("result_o", e.res, result);
				if (rd_out !== e.rd)
					report_value("rd_o", 64'(e.rd), 64'(rd_out));
				if (reg_wen_out !== e.wen)
					report_value("reg_wen_o", 64'(e.wen), 64'(reg_wen_out));
				if (pc_out !== e.pc)
					report_value("pc_o", e.pc, pc_out);
			end
		end
	end

	initial begin
		int               waited;
		rv_ex_pkg::xlen_t a;
		rv_ex_pkg::xlen_t b;
		rv_ex_pkg::xlen_t k;
		rv_ex_pkg::xlen_t min_neg;
		issue_valid = 1'b0;
		alu_op      = rv_ex_pkg::OP_ADD;
		src1        = '0;
		src2        = '0;
		rd          = '0;
		reg_wen     = 1'b0;
		pc          = '0;
		flush       = 1'b0;
		lfsr_q      = 16'd25355;
		pc_next     = 64'h1000;
		err_cnt     = 0;
		to_cnt      = 0;
		min_neg     = {1'b1, 63'b0};

		@(negedge clk); // still in reset
		if (valid !== 1'b0)
			report_value("valid_o", 64'd0, 64'(valid));
		if (reg_wen_out !== 1'b0)
			report_value("reg_wen_o", 64'd0, 64'(reg_wen_out));
		if (stall !== 1'b0)
			report_value("stall_o", 64'd0, 64'(stall));
		if (result !== '0)
			report_value("result_o", 64'd0, result);
		if (rd_out !== '0)
			report_value("rd_o", 64'd0, 64'(rd_out));
		if (pc_out !== `RV_RESET_PC)
			report_value("pc_o", `RV_RESET_PC, pc_out);

		waited = 0;
		while (!rst_n) begin
			@(posedge clk);
			waited++;
			if (waited > 10) begin
				$display("timeout: reset was never released");
				to_cnt++;
				finish_run();
			end
		end
		@(negedge clk);

		// back to back alu ops
		for (int i = 0; i < 200; i++) begin
			take_bits(4, k);
			take_bits(64, a);
			take_bits(64, b);
			issue_op(rv_ex_pkg::alu_op_e'(5'(k % 10)), a, b);
		end

		for (int i = 0; i < 30; i++) begin
			take_bits(3, k);
			take_bits(64, a);
			take_bits(64, b);
			issue_op(rv_ex_pkg::alu_op_e'(5'd16 + 5'(k % 6)), a, b);
		end

		// riscv corner cases
		issue_op(rv_ex_pkg::OP_DIV, 64'd1234, 64'd0);
		issue_op(rv_ex_pkg::OP_DIVU, 64'hdead_beef, 64'd0);
		issue_op(rv_ex_pkg::OP_REM, -64'sd77, 64'd0);
		issue_op(rv_ex_pkg::OP_REMU, 64'hfeed, 64'd0);
		issue_op(rv_ex_pkg::OP_DIV, min_neg, '1);
		issue_op(rv_ex_pkg::OP_REM, min_neg, '1);
		issue_op(rv_ex_pkg::OP_DIV, -64'sd100, 64'd7);
		issue_op(rv_ex_pkg::OP_REM, -64'sd100, 64'd7);

		// flush during a stall, no result for that op
		issue_valid = 1'b1;
		alu_op      = rv_ex_pkg::OP_DIVU;
		src1        = 64'd999;
		src2        = 64'd3;
		#1;
		if (!stall)
			report_value("stall_o on divu", 64'd1, 64'd0);
		repeat (5) @(negedge clk);
		flush       = 1'b1;
		issue_valid = 1'b0;
		@(negedge clk);
		flush = 1'b0;
		if (stall !== 1'b0)
			report_value("stall_o after flush", 64'd0, 64'(stall));
		if (valid !== 1'b0)
			report_value("valid_o after flush", 64'd0, 64'(valid));
		issue_op(rv_ex_pkg::OP_ADD, 64'd40, 64'd2);

		waited = 0;
		while (exp_q.size() != 0) begin
			@(negedge clk);
			waited++;
			if (waited > 5) begin
				$display("timeout: %0d results never arrived", exp_q.size());
				to_cnt++;
				finish_run();
			end
		end
		@(negedge clk);
		finish_run();
	end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+hw
hw/rv_ex_pkg.sv
hw/rv_alu.sv
hw/rv_muldiv.sv
hw/rv_ex_mem_regs.sv
hw/rv_ex_top.sv
dv/tb_clkgen.sv
dv/rv_ex_props.sv
dv/rv_ex_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the execute-stage testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module rv_ex_tb -f sim.f -o rv_ex_sim

out="$(./obj_dir/rv_ex_sim)"
echo "$out"

if grep -q "Done: no errors" <<< "$out"; then
	exit 0
else
	exit 1
fi
